// ==== design/bridge_pkg.sv ====
// Shared widths, phase encoding and phase decode helpers for the CPU bus bridge, imported by RTL and testbench
`default_nettype none

package bridge_pkg;

  localparam int BUS_W      = 32;                 // CPU address and data word width
  localparam int PIN_W      = 8;                  // Width of each pin group
  localparam int BUS_BYTES  = BUS_W / PIN_W;      // Bytes per word, 4
  localparam int PHASE_W    = 4;                  // Phase code width
  localparam int BYTE_SEL_W = $clog2(BUS_BYTES);  // Byte index width

  // One bus cycle walks IDLE, four address phases, four data phases, back to IDLE
  typedef enum logic [PHASE_W-1:0] {
    PH_IDLE  = 4'd0,
    PH_ADDR0 = 4'd1,  // Address byte 0, least significant
    PH_ADDR1 = 4'd2,
    PH_ADDR2 = 4'd3,
    PH_ADDR3 = 4'd4,
    PH_DATA0 = 4'd5,  // Data byte 0, least significant
    PH_DATA1 = 4'd6,
    PH_DATA2 = 4'd7,
    PH_DATA3 = 4'd8
  } bus_phase_e;

  function automatic logic is_addr_phase(input bus_phase_e ph);
    return (ph >= PH_ADDR0) && (ph <= PH_ADDR3);
  endfunction

  function automatic logic is_data_phase(input bus_phase_e ph);
    return (ph >= PH_DATA0) && (ph <= PH_DATA3);
  endfunction

  // Byte position within the word for an address or data phase
  function automatic logic [BYTE_SEL_W-1:0] byte_index(input bus_phase_e ph);
    logic [BYTE_SEL_W-1:0] idx;
    case (ph)
      PH_ADDR1, PH_DATA1: idx = 2'd1;
      PH_ADDR2, PH_DATA2: idx = 2'd2;
      PH_ADDR3, PH_DATA3: idx = 2'd3;
      default:            idx = 2'd0;  // Byte 0 phases and idle
    endcase
    return idx;
  endfunction

endpackage

`default_nettype wire

// ==== design/bus_cycle_ctrl.sv ====
// Bus cycle FSM: accepts a CPU request, steps address and data phases, sets pin direction and pulses done
`default_nettype none

module bus_cycle_ctrl import bridge_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             req,     // CPU request level
  input  logic             we,      // 1 = write cycle
  output bus_phase_e       phase,   // Current phase to the datapath blocks
  output logic             start,   // High in the accept cycle
  output logic             sample,  // Read data phase, assembler takes uio_in
  output logic             busy,
  output logic             done,    // One-cycle completion pulse
  output logic             frame,
  output logic [PIN_W-1:0] uio_oe
);

  bus_phase_e phase_q;
  bus_phase_e phase_next;
  logic       we_q;       // Cycle type held for the whole cycle
  logic       in_data;

  assign busy    = (phase_q != PH_IDLE);
  assign start   = req && !busy;  // New cycle may begin in the done cycle
  assign in_data = is_data_phase(phase_q);

  // Next phase, fixed sequence with no wait states
  always_comb begin
    case (phase_q)
      PH_IDLE:  phase_next = start ? PH_ADDR0 : PH_IDLE;
      PH_ADDR0: phase_next = PH_ADDR1;
      PH_ADDR1: phase_next = PH_ADDR2;
      PH_ADDR2: phase_next = PH_ADDR3;
      PH_ADDR3: phase_next = PH_DATA0;
      PH_DATA0: phase_next = PH_DATA1;
      PH_DATA1: phase_next = PH_DATA2;
      PH_DATA2: phase_next = PH_DATA3;
      PH_DATA3: phase_next = PH_IDLE;
      default:  phase_next = PH_IDLE;  // Unused codes recover to idle
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase_q <= PH_IDLE;
      we_q    <= 1'b0;
      done    <= 1'b0;
    end else begin
      phase_q <= phase_next;
      if (start) begin
        we_q <= we;  // Type fixed at accept
      end
      // Both halves finish together on the step out of the last data phase
      done <= (phase_q == PH_DATA3);
    end
  end

  assign phase  = phase_q;
  assign frame  = busy;                          // Address and data phases
  assign sample = in_data && !we_q;              // Device drives uio_in
  assign uio_oe = {PIN_W{in_data && we_q}};      // Bridge drives uio only for writes

endmodule

`default_nettype wire

// ==== design/addr_wdata_serializer.sv ====
// Outbound serializer: latches address and write data at cycle start, drives the byte of the current phase
`default_nettype none

module addr_wdata_serializer import bridge_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             start,    // Accept cycle from the controller
  input  logic             we,
  input  bus_phase_e       phase,
  input  logic [BUS_W-1:0] addr,
  input  logic [BUS_W-1:0] wdata,
  output logic [PIN_W-1:0] uo_out,   // Address byte pins
  output logic [PIN_W-1:0] uio_out   // Write data byte pins
);

  logic [BUS_W-1:0]      addr_q;
  logic [BUS_W-1:0]      wdata_q;
  logic                  we_q;
  logic [BYTE_SEL_W-1:0] sel;
  logic                  addr_en;
  logic                  wdata_en;

  // Cycle type latched at accept
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      we_q <= 1'b0;
    end else if (start) begin
      we_q <= we;
    end
  end

  // Payload held so the CPU can move on during the cycle
  always_ff @(posedge clk) begin
    if (start) begin
      addr_q  <= addr;
      wdata_q <= wdata;
    end
  end

  assign sel      = byte_index(phase);
  assign addr_en  = is_addr_phase(phase);
  assign wdata_en = is_data_phase(phase) && we_q;

  // Byte select straight from the phase, same cycle
  always_comb begin
    uo_out = '0;
    if (addr_en) begin
      uo_out = addr_q[sel*PIN_W +: PIN_W];
    end
  end

  always_comb begin
    uio_out = '0;  // Quiet in reads and outside data phases
    if (wdata_en) begin
      uio_out = wdata_q[sel*PIN_W +: PIN_W];
    end
  end

endmodule

`default_nettype wire

// ==== design/rdata_assembler.sv ====
// Inbound read data assembler: shifts one pin byte in per sample edge and holds the finished read word
`default_nettype none

module rdata_assembler import bridge_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             sample,  // High in read data phases
  input  logic [PIN_W-1:0] uio_in,  // Byte from the device
  output logic [BUS_W-1:0] rdata
);

  logic [BUS_W-1:0] word_q;
  logic [BUS_W-1:0] word_next;

  // New byte enters at the top, so byte 0 ends at the bottom after four samples
  assign word_next = {uio_in, word_q[BUS_W-1:PIN_W]};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      word_q <= '0;
    end else if (sample) begin
      word_q <= word_next;
    end
    // Otherwise the last read word stays visible
  end

  assign rdata = word_q;

endmodule

`default_nettype wire

// ==== design/cpu_bus_bridge.sv ====
// Top of the CPU bus bridge: joins the cycle FSM, outbound serializer and read assembler to CPU and pins
`default_nettype none

module cpu_bus_bridge import bridge_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  // CPU side
  input  logic             req,
  input  logic             we,
  input  logic [BUS_W-1:0] addr,
  input  logic [BUS_W-1:0] wdata,
  output logic             busy,
  output logic             done,
  output logic [BUS_W-1:0] rdata,
  // Pin side
  output logic             frame,
  output logic [PIN_W-1:0] uo_out,
  output logic [PIN_W-1:0] uio_out,
  output logic [PIN_W-1:0] uio_oe,
  input  logic [PIN_W-1:0] uio_in
);

  bus_phase_e phase;
  logic       start;
  logic       sample;

  bus_cycle_ctrl bus_cycle_ctrl_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .req    (req),
    .we     (we),
    .phase  (phase),
    .start  (start),
    .sample (sample),
    .busy   (busy),
    .done   (done),
    .frame  (frame),
    .uio_oe (uio_oe)
  );

  addr_wdata_serializer addr_wdata_serializer_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .we      (we),
    .phase   (phase),
    .addr    (addr),
    .wdata   (wdata),
    .uo_out  (uo_out),
    .uio_out (uio_out)
  );

  rdata_assembler rdata_assembler_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .sample (sample),
    .uio_in (uio_in),
    .rdata  (rdata)
  );

endmodule

`default_nettype wire

// ==== test/cpu_bus_bridge_properties.sv ====
// Assertions on phase order, done timing and uio direction, bound into every bus cycle controller
`default_nettype none

module bus_cycle_assertions import bridge_pkg::*; (
  input logic             clk,
  input logic             rst_n,
  input logic             start,
  input logic             done,
  input logic             we,      // CPU cycle type, taken at accept
  input bus_phase_e       phase,
  input logic [PIN_W-1:0] uio_oe
);

  timeunit 1ns;
  timeprecision 1ps;

  int                 assert_fails = 0;  // Failed assertion count
  logic [PHASE_W-1:0] phase_code;

  assign phase_code = phase;

  // Fixed walk through address and data phases
  phase_step: assert property (@(posedge clk) disable iff (!rst_n)
      (phase != PH_IDLE && phase != PH_DATA3) |=> (phase_code == $past(phase_code) + 1'b1))
    else begin $error("phase did not advance by one"); assert_fails++; end

  last_to_idle: assert property (@(posedge clk) disable iff (!rst_n)
      (phase == PH_DATA3) |=> (phase == PH_IDLE))
    else begin $error("PH_DATA3 not followed by PH_IDLE"); assert_fails++; end

  accept_to_addr0: assert property (@(posedge clk) disable iff (!rst_n)
      start |=> (phase == PH_ADDR0))
    else begin $error("accepted request did not enter PH_ADDR0"); assert_fails++; end

  idle_holds: assert property (@(posedge clk) disable iff (!rst_n)
      (phase == PH_IDLE && !start) |=> (phase == PH_IDLE))
    else begin $error("cycle started without a request"); assert_fails++; end

  // done one cycle after the last data phase of an accepted cycle
  done_follows: assert property (@(posedge clk) disable iff (!rst_n)
      start |-> ##8 (phase == PH_DATA3) ##1 done)
    else begin $error("done missing one cycle after PH_DATA3"); assert_fails++; end

  no_done_from_idle: assert property (@(posedge clk) disable iff (!rst_n)
      (phase == PH_IDLE) |=> !done)
    else begin $error("done raised after an idle cycle"); assert_fails++; end

  read_no_drive: assert property (@(posedge clk) disable iff (!rst_n)
      (start && !we) |=> (uio_oe == '0) [*8])
    else begin $error("uio_oe active in a read cycle"); assert_fails++; end

  write_drive: assert property (@(posedge clk) disable iff (!rst_n)
      (start && we) |-> ##5 (uio_oe == '1) [*4])
    else begin $error("uio_oe not all ones in a write data phase"); assert_fails++; end

endmodule

bind bus_cycle_ctrl bus_cycle_assertions bus_cycle_assertions_inst (
  .clk    (clk),
  .rst_n  (rst_n),
  .start  (start),
  .done   (done),
  .we     (we),
  .phase  (phase_q),
  .uio_oe (uio_oe)
);

`default_nettype wire

// ==== test/cpu_bus_bridge_tb.sv ====
// Self-checking testbench for the CPU bus bridge: LFSR random cycles against a pin device and a memory model
`default_nettype none

module cpu_bus_bridge_tb import bridge_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int          CLK_PERIOD      = 8;
  localparam int          RESET_CYCLES    = 10;
  localparam int          IDLE_CHECK      = 6;      // Quiet cycles watched after reset
  localparam int          N_CYCLES        = 200;
  localparam int          MEM_DEPTH       = 16;     // Words per memory, indexed by addr[5:2]
  localparam int          DONE_EDGES      = 9;      // Accept edge to done
  localparam int          DONE_LIMIT      = 20;
  localparam int          WATCHDOG_CYCLES = N_CYCLES * 12 + RESET_CYCLES + IDLE_CHECK + 8;
  localparam logic [31:0] LFSR_SEED       = 32'd80420;

  logic             clk;
  logic             rst_n;
  logic             req;
  logic             we;
  logic [BUS_W-1:0] addr;
  logic [BUS_W-1:0] wdata;
  logic             busy;
  logic             done;
  logic [BUS_W-1:0] rdata;
  logic             frame;
  logic [PIN_W-1:0] uo_out;
  logic [PIN_W-1:0] uio_out;
  logic [PIN_W-1:0] uio_oe;
  logic [PIN_W-1:0] uio_in;

  logic [31:0]      lfsr_state;
  logic [BUS_W-1:0] ref_data [MEM_DEPTH];  // Expected memory, written from the CPU side
  logic [BUS_W-1:0] ref_tag  [MEM_DEPTH];
  bit               ref_vld  [MEM_DEPTH];
  logic [BUS_W-1:0] dev_data [MEM_DEPTH];  // Device memory, written from the pins
  logic [BUS_W-1:0] dev_tag  [MEM_DEPTH];
  bit               dev_vld  [MEM_DEPTH];
  logic [2:0]       dev_cnt;               // Frame cycle count seen by the device
  logic [BUS_W-1:0] dev_addr;
  logic [BUS_W-1:0] dev_rword;
  logic [BUS_W-1:0] dev_wword;
  logic [BUS_W-1:0] last_waddr;
  logic             have_waddr;
  logic [BUS_W-1:0] last_rdata;            // Word of the latest read

  cpu_bus_bridge cpu_bus_bridge_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .req     (req),
    .we      (we),
    .addr    (addr),
    .wdata   (wdata),
    .busy    (busy),
    .done    (done),
    .rdata   (rdata),
    .frame   (frame),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe),
    .uio_in  (uio_in)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [BUS_W-1:0] val);
    int b;
    val = '0;
    for (b = 0; b < n; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[BUS_W-2:0], lfsr_state[0]};
    end
  endtask

  // Contents of a word never written, byte-swapped address with a mask
  function automatic logic [BUS_W-1:0] fill_word(input logic [BUS_W-1:0] a);
    return {a[7:0], a[15:8], a[23:16], a[31:24]} ^ 32'h5A3C_96E1;
  endfunction

  function automatic int slot_of(input logic [BUS_W-1:0] a);
    return int'(a[5:2]);
  endfunction

  function automatic logic [BUS_W-1:0] ref_lookup(input logic [BUS_W-1:0] a);
    int s;
    s = slot_of(a);
    if (ref_vld[s] && ref_tag[s] == a) begin
      return ref_data[s];
    end
    return fill_word(a);
  endfunction

  function automatic logic [BUS_W-1:0] dev_lookup(input logic [BUS_W-1:0] a);
    int s;
    s = slot_of(a);
    if (dev_vld[s] && dev_tag[s] == a) begin
      return dev_data[s];
    end
    return fill_word(a);
  endfunction

  task automatic ref_store(input logic [BUS_W-1:0] a, input logic [BUS_W-1:0] d);
    int s;
    s = slot_of(a);
    ref_data[s] = d;
    ref_tag[s]  = a;
    ref_vld[s]  = 1'b1;
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("tests failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic compare_word(input string name, input logic [BUS_W-1:0] got,
                              input logic [BUS_W-1:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic compare_byte(input string name, input logic [PIN_W-1:0] got,
                              input logic [PIN_W-1:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic expect_quiet_pins();
    compare_flag("busy", busy, 1'b0);
    compare_flag("done", done, 1'b0);
    compare_flag("frame", frame, 1'b0);
    compare_byte("uio_oe", uio_oe, '0);
    compare_byte("uo_out", uo_out, '0);
    compare_byte("uio_out", uio_out, '0);
  endtask

  // One random cycle, sometimes aimed at the last written address
  task automatic pick_cycle(output logic w, output logic [BUS_W-1:0] a,
                            output logic [BUS_W-1:0] d);
    logic [BUS_W-1:0] bits;
    draw_bits(1, bits);
    w = bits[0];
    draw_bits(BUS_W, a);
    draw_bits(BUS_W, d);
    draw_bits(1, bits);
    if (bits[0] && have_waddr) begin
      a = last_waddr;
    end
    if (w) begin
      last_waddr = a;
      have_waddr = 1'b1;
    end
  endtask

  // Called on the accept edge, checks every phase and the done cycle
  task automatic follow_cycle(input logic w, input logic [BUS_W-1:0] a,
                              input logic [BUS_W-1:0] d, input int hold);
    logic [BUS_W-1:0] exp;
    int               k;
    for (k = 1; k < DONE_EDGES; k++) begin
      @(negedge clk);
      compare_flag("frame", frame, 1'b1);
      compare_flag("busy", busy, 1'b1);
      compare_flag("done", done, 1'b0);
      if (k <= BUS_BYTES) begin
        compare_byte("uo_out", uo_out, a[(k-1)*PIN_W +: PIN_W]);
        compare_byte("uio_oe", uio_oe, '0);
        compare_byte("uio_out", uio_out, '0);
      end else begin
        compare_byte("uo_out", uo_out, '0);
        compare_byte("uio_oe", uio_oe, {PIN_W{w}});
        compare_byte("uio_out", uio_out, w ? d[(k-1-BUS_BYTES)*PIN_W +: PIN_W] : '0);
      end
      @(posedge clk);
      if (k == hold) begin
        req <= 1'b0;  // End of the ignored request while busy
      end
    end
    @(negedge clk);
    while (!done && k < DONE_LIMIT) begin
      @(negedge clk);
      k++;
    end
    if (!done) begin
      report_failure("done never came after an accepted request");
    end
    compare_word("done edge count", k, DONE_EDGES);
    compare_flag("frame", frame, 1'b0);
    compare_flag("busy", busy, 1'b0);
    compare_byte("uo_out", uo_out, '0);
    compare_byte("uio_oe", uio_oe, '0);
    if (w) begin
      compare_word("device memory", dev_lookup(a), d);
      compare_word("rdata", rdata, last_rdata);  // Write leaves the read word alone
      ref_store(a, d);
    end else begin
      exp = ref_lookup(a);
      compare_word("rdata", rdata, exp);
      last_rdata = exp;
    end
  endtask

  // Pin-side device: rebuilds the address from uo_out, keeps write bytes, answers reads on uio_in
  always @(posedge clk) begin : device_model
    logic [BUS_W-1:0] found;
    if (!rst_n || !frame) begin
      dev_cnt <= '0;
      uio_in  <= '0;
    end else begin
      dev_cnt <= dev_cnt + 3'd1;
      case (dev_cnt)
        3'd3: begin
          found = dev_lookup({uo_out, dev_addr[BUS_W-PIN_W-1:0]});
          dev_addr[BUS_W-1 -: PIN_W] <= uo_out;
          uio_in    <= found[PIN_W-1:0];  // Byte 0 for the first data phase
          dev_rword <= found >> PIN_W;
        end
        3'd4, 3'd5, 3'd6: begin
          uio_in    <= dev_rword[PIN_W-1:0];
          dev_rword <= dev_rword >> PIN_W;
          if (uio_oe == '1) begin
            dev_wword <= {uio_out, dev_wword[BUS_W-1:PIN_W]};
          end
        end
        3'd7: begin
          uio_in <= '0;
          if (uio_oe == '1) begin
            dev_data[slot_of(dev_addr)] <= {uio_out, dev_wword[BUS_W-1:PIN_W]};
            dev_tag[slot_of(dev_addr)]  <= dev_addr;
            dev_vld[slot_of(dev_addr)]  <= 1'b1;
          end
        end
        default: dev_addr[dev_cnt*PIN_W +: PIN_W] <= uo_out;  // Address bytes 0 to 2
      endcase
    end
  end

  // Watch the bound controller assertions
  always @(negedge clk) begin : assertion_watch
    if (cpu_bus_bridge_inst.bus_cycle_ctrl_inst.bus_cycle_assertions_inst.assert_fails != 0) begin
      report_failure("a concurrent assertion in the bus cycle controller failed");
    end
  end

  initial begin : main_flow
    logic             cur_we;
    logic             nxt_we;
    logic [BUS_W-1:0] cur_addr;
    logic [BUS_W-1:0] nxt_addr;
    logic [BUS_W-1:0] cur_wdata;
    logic [BUS_W-1:0] nxt_wdata;
    logic [BUS_W-1:0] bits;
    logic             pending;
    logic             back_to_back;
    int               hold;
    int               n;
    clk        = 1'b0;
    rst_n      = 1'b0;
    req        = 1'b0;
    we         = 1'b0;
    addr       = '0;
    wdata      = '0;
    uio_in     = '0;
    lfsr_state = LFSR_SEED;
    have_waddr = 1'b0;
    last_rdata = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    repeat (IDLE_CHECK) begin
      @(negedge clk);
      expect_quiet_pins();
      compare_word("rdata", rdata, '0);
    end
    pick_cycle(cur_we, cur_addr, cur_wdata);
    pending = 1'b0;
    for (n = 0; n < N_CYCLES; n++) begin
      if (!pending) begin
        draw_bits(1, bits);
        repeat (bits[0]) begin
          @(negedge clk);
          expect_quiet_pins();
        end
        @(posedge clk);
        req   <= 1'b1;
        we    <= cur_we;
        addr  <= cur_addr;
        wdata <= cur_wdata;
        @(negedge clk);
      end
      while (busy) @(negedge clk);  // Back-to-back request waits for the done cycle
      @(posedge clk);
      draw_bits(1, bits);
      back_to_back = bits[0] && (n < N_CYCLES - 1);
      pick_cycle(nxt_we, nxt_addr, nxt_wdata);
      if (back_to_back) begin
        we    <= nxt_we;  // Next cycle waits on the pins, req stays high
        addr  <= nxt_addr;
        wdata <= nxt_wdata;
        hold  = DONE_LIMIT;
      end else begin
        draw_bits(1, bits);
        we <= bits[0];
        draw_bits(BUS_W, bits);
        addr <= bits;
        draw_bits(BUS_W, bits);
        wdata <= bits;
        draw_bits(2, bits);
        hold = int'(bits[1:0]);
        if (hold == 0) begin
          req <= 1'b0;
        end
      end
      follow_cycle(cur_we, cur_addr, cur_wdata, hold);
      cur_we    = nxt_we;
      cur_addr  = nxt_addr;
      cur_wdata = nxt_wdata;
      pending   = back_to_back;
    end
    @(negedge clk);
    expect_quiet_pins();
    if (cpu_bus_bridge_inst.bus_cycle_ctrl_inst.bus_cycle_assertions_inst.assert_fails == 0) begin
      $display("all tests passed");
    end else begin
      report_failure("concurrent assertions in the bus cycle controller failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    report_failure("Timeout: the bus cycles did not finish in the allowed time");
  end

endmodule

`default_nettype wire

// ==== cpu_bus_bridge.f ====
design/bridge_pkg.sv
design/bus_cycle_ctrl.sv
design/addr_wdata_serializer.sv
design/rdata_assembler.sv
design/cpu_bus_bridge.sv
test/cpu_bus_bridge_properties.sv
test/cpu_bus_bridge_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_bus_bridge

sources:
  # RTL in compile order
  - files:
      - design/bridge_pkg.sv
      - design/bus_cycle_ctrl.sv
      - design/addr_wdata_serializer.sv
      - design/rdata_assembler.sv
      - design/cpu_bus_bridge.sv

  # Testbench and bound assertions
  - target: test
    files:
      - test/cpu_bus_bridge_properties.sv
      - test/cpu_bus_bridge_tb.sv
